//--- dv/rv_core_tb.sv
// random 64-word program with seed 93; imem is loaded before start and hold is the only stall
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int PROG_LEN       = 64;
    localparam int TIMEOUT_CYCLES = 8 + PROG_LEN + PROG_LEN * 6 + 50;

    typedef logic [31:0][31:0] reg_file_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   imem_we;
    rv_core_pkg::imem_idx_t imem_idx;
    rv_core_pkg::word_t     imem_data;
    logic                   start;
    logic [6:0]             prog_len;
    logic                   hold;
    logic                   retire_valid;
    rv_core_pkg::retire_t   retire;

    integer                 seed;
    rv_core_pkg::word_t     prog [PROG_LEN];
    reg_file_t              model_regs;
    rv_core_pkg::retire_t   exp_rec;
    logic                   started;
    int                     n_retired;
    int                     cycles;
    int                     mismatches;
    int                     protocol_errors;

    rv_core_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .imem_we      (imem_we),
        .imem_idx     (imem_idx),
        .imem_data    (imem_data),
        .start        (start),
        .prog_len     (prog_len),
        .hold         (hold),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #50 clk = ~clk;

    function automatic rv_core_pkg::word_t alu_model(
        input logic [2:0]         funct3,
        input logic               alt,
        input rv_core_pkg::word_t a,
        input rv_core_pkg::word_t b
    );
        rv_core_pkg::word_t res;
        case (funct3)
            3'b000: res = alt ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: res = (a < b) ? 32'd1 : 32'd0;
            3'b100: res = a ^ b;
            3'b101: begin
                if (alt) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'b110: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    // expected retire record for one instruction in program order
    function automatic rv_core_pkg::retire_t expected_retire(
        input reg_file_t          regs,
        input rv_core_pkg::addr_t pc,
        input rv_core_pkg::word_t instr
    );
        rv_core_pkg::retire_t rec;
        rv_core_pkg::word_t   rs1_val;
        rv_core_pkg::word_t   imm_i;
        logic                 supported;
        rec       = '0;
        rec.pc    = pc;
        rec.rd    = instr[11:7];
        rs1_val   = regs[instr[19:15]];
        imm_i     = {{20{instr[31]}}, instr[31:20]};
        supported = 1'b1;
        case (instr[6:0])
            rv_core_pkg::OP_LUI:   rec.value = {instr[31:12], 12'h000};
            rv_core_pkg::OP_AUIPC: rec.value = pc + {instr[31:12], 12'h000};
            // bit 30 only means srai here
            rv_core_pkg::OP_IMM: begin
                rec.value = alu_model(instr[14:12], instr[30] && instr[14:12] == 3'b101,
                                      rs1_val, imm_i);
            end
            rv_core_pkg::OP_OP: begin
                rec.value = alu_model(instr[14:12], instr[30], rs1_val, regs[instr[24:20]]);
            end
            default: supported = 1'b0;
        endcase
        rec.wr_en = supported && (rec.rd != 5'd0);
        return rec;
    endfunction

    task automatic check_field(input string name, input int idx,
                               input rv_core_pkg::word_t expected,
                               input rv_core_pkg::word_t actual);
        assert (actual === expected) else begin
            mismatches++;
            $display("Error %s insn %0d: expected 0x%08h, actual 0x%08h",
                     name, idx, expected, actual);
        end
    endtask

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic build_program();
        rv_core_pkg::word_t w;
        int                 kind;
        for (int i = 0; i < PROG_LEN; i++) begin
            w    = $random(seed);
            kind = $unsigned($random(seed)) % 10;
            // more x0 destinations than random fields give
            if (($random(seed) & 7) == 0) begin
                w[11:7] = 5'd0;
            end
            case (kind)
                0, 1: w[6:0] = rv_core_pkg::OP_LUI;
                2, 3: w[6:0] = rv_core_pkg::OP_AUIPC;
                4, 5: begin
                    w[6:0] = rv_core_pkg::OP_IMM;
                    // shifts carry funct7, srai keeps bit 30
                    if (w[13:12] == 2'b01) begin
                        w[31:25] = {1'b0, w[14] & w[30], 5'd0};
                    end
                end
                6, 7: begin
                    w[6:0]   = rv_core_pkg::OP_OP;
                    w[31:25] = {1'b0, w[30] && (w[14:12] == 3'b000 || w[14:12] == 3'b101), 5'd0};
                end
                default: begin
                    case ($unsigned($random(seed)) % 7)
                        0: w[6:0] = rv_core_pkg::OP_JAL;
                        1: w[6:0] = rv_core_pkg::OP_JALR;
                        2: w[6:0] = rv_core_pkg::OP_BRANCH;
                        3: w[6:0] = rv_core_pkg::OP_LOAD;
                        4: w[6:0] = rv_core_pkg::OP_STORE;
                        5: w[6:0] = rv_core_pkg::OP_FENCE;
                        default: w[6:0] = rv_core_pkg::OP_SYSTEM;
                    endcase
                end
            endcase
            prog[i] = w;
        end
    endtask

    task automatic print_counts();
        $display("retired %0d of %0d, %0d value mismatches, %0d protocol errors",
                 n_retired, PROG_LEN, mismatches, protocol_errors);
    endtask

    // comparing process, sampled away from the rising edge
    always @(negedge clk) begin
        if (retire_valid !== 1'b0) begin
            assert (started) else begin
                protocol_errors++;
                $display("retire_valid high before start, pc 0x%08h", retire.pc);
            end
            assert (n_retired < PROG_LEN) else begin
                protocol_errors++;
                $display("extra retirement after %0d instructions, pc 0x%08h",
                         PROG_LEN, retire.pc);
            end
            if (started && n_retired < PROG_LEN) begin
                exp_rec = expected_retire(model_regs, rv_core_pkg::addr_t'(n_retired * 4),
                                          prog[n_retired]);
                check_field("retire_pc", n_retired, exp_rec.pc, retire.pc);
                check_field("retire_rd", n_retired, 32'(exp_rec.rd), 32'(retire.rd));
                check_field("write_flag", n_retired, 32'(exp_rec.wr_en), 32'(retire.wr_en));
                if (exp_rec.wr_en) begin
                    check_field("write_value", n_retired, exp_rec.value, retire.value);
                    model_regs[exp_rec.rd] = exp_rec.value;
                end
                n_retired++;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, only %0d of %0d instructions retired",
                     TIMEOUT_CYCLES, n_retired, PROG_LEN);
            print_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        reset           = 1'b1;
        imem_we         = 1'b0;
        imem_idx        = '0;
        imem_data       = '0;
        start           = 1'b0;
        prog_len        = '0;
        hold            = 1'b0;
        seed            = 93;
        model_regs      = '0;
        started         = 1'b0;
        n_retired       = 0;
        cycles          = 0;
        mismatches      = 0;
        protocol_errors = 0;
        build_program();

        repeat (8) step_clock();
        reset = 1'b0;

        for (int i = 0; i < PROG_LEN; i++) begin
            imem_we   = 1'b1;
            imem_idx  = rv_core_pkg::imem_idx_t'(i);
            imem_data = prog[i];
            step_clock();
        end
        imem_we = 1'b0;

        start    = 1'b1;
        prog_len = 7'(PROG_LEN);
        started  = 1'b1;
        step_clock();
        start = 1'b0;

        // hold bursts longer than the queue depth
        for (int b = 0; b < 10; b++) begin
            hold = 1'b1;
            repeat (5 + $unsigned($random(seed)) % 4) step_clock();
            hold = 1'b0;
            repeat (2 + $unsigned($random(seed)) % 8) step_clock();
        end

        while (n_retired < PROG_LEN) begin
            step_clock();
        end
        // window for any extra retirement
        repeat (20) step_clock();

        print_counts();
        if (mismatches == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
// executes one instruction per pop; the retire record comes one cycle after the pop
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   head_valid,
    input  rv_core_pkg::fetch_pkt_t     head_pkt,
    input  wire logic                   hold,
    output logic                        pop,
    output logic                        retire_valid,
    output rv_core_pkg::retire_t        retire
);

    // x0 is never written, so it stays zero after reset
    rv_core_pkg::word_t    regs [32];
    rv_core_pkg::decoded_t dec;
    rv_core_pkg::word_t    rs1_val;
    rv_core_pkg::word_t    rs2_val;
    rv_core_pkg::word_t    result;
    logic                  wr;

    assign pop = head_valid && !hold;

    insn_decoder i_decoder (
        .instr (head_pkt.instr),
        .dec   (dec)
    );

    assign rs1_val = regs[dec.rs1];
    assign rs2_val = regs[dec.rs2];

    int_alu i_alu (
        .dec     (dec),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .pc      (head_pkt.pc),
        .result  (result)
    );

    assign wr = pop && dec.wb_en && (dec.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr) begin
            regs[dec.rd] <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= pop;
        end
    end

    // retire payload, qualified by retire_valid
    always_ff @(posedge clk) begin
        if (pop) begin
            retire <= '{pc: head_pkt.pc, rd: dec.rd, value: result, wr_en: wr};
        end
    end

endmodule

`default_nettype wire

//--- hdl/insn_decoder.sv
// only LUI, AUIPC, OP-IMM and OP write back; all other opcodes decode to a zero-result no-op
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
    input  rv_core_pkg::word_t    instr,
    output rv_core_pkg::decoded_t dec
);

    rv_core_pkg::reg_idx_t rs1;
    rv_core_pkg::reg_idx_t rs2;
    rv_core_pkg::reg_idx_t rd;
    logic [2:0]            funct3;
    rv_core_pkg::opcode_t  opcode;
    rv_core_pkg::word_t    imm_u;
    rv_core_pkg::word_t    imm_i;

    // R-type field split, shared by all formats
    assign rs2    = instr[24:20];
    assign rs1    = instr[19:15];
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign opcode = rv_core_pkg::opcode_t'(instr[6:0]);

    // upper immediate
    assign imm_u = {instr[31:12], 12'h000};
    // sign-extended 12-bit immediate
    assign imm_i = {{20{instr[31]}}, instr[31:20]};

    always_comb begin
        // x0 operands with a zero immediate, so the ALU result is zero
        dec    = '0;
        dec.rd = rd;

        case (opcode)
            rv_core_pkg::OP_LUI: begin
                dec.imm       = imm_u;
                dec.alu_a_sel = rv_core_pkg::A_ZERO;
                dec.alu_b_sel = rv_core_pkg::B_IMM;
                dec.alu_op    = rv_core_pkg::ALU_ADD;
                dec.wb_en     = 1'b1;
            end

            rv_core_pkg::OP_AUIPC: begin
                dec.imm       = imm_u;
                dec.alu_a_sel = rv_core_pkg::A_PC;
                dec.alu_b_sel = rv_core_pkg::B_IMM;
                dec.alu_op    = rv_core_pkg::ALU_ADD;
                dec.wb_en     = 1'b1;
            end

            rv_core_pkg::OP_IMM: begin
                dec.rs1       = rs1;
                dec.imm       = imm_i;
                dec.alu_a_sel = rv_core_pkg::A_RS1;
                dec.alu_b_sel = rv_core_pkg::B_IMM;
                dec.alu_op    = rv_core_pkg::alu_op_t'(funct3);
                // bit 30 of addi is immediate, not subtract
                dec.sub_arith = (funct3 == 3'b101) ? instr[30] : 1'b0;
                dec.wb_en     = 1'b1;
            end

            rv_core_pkg::OP_OP: begin
                dec.rs1       = rs1;
                dec.rs2       = rs2;
                dec.alu_a_sel = rv_core_pkg::A_RS1;
                dec.alu_b_sel = rv_core_pkg::B_RS2;
                dec.alu_op    = rv_core_pkg::alu_op_t'(funct3);
                dec.sub_arith = instr[30];
                dec.wb_en     = 1'b1;
            end

            // JAL, JALR, BRANCH, LOAD, STORE, FENCE and SYSTEM just retire,
            // no data memory, CSRs or redirect
            default: begin
                dec.wb_en = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/insn_fetch.sv
// program memory is loaded only while idle; prog_len of zero starts nothing
`timescale 1ns/1ps
`default_nettype none

module insn_fetch (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   imem_we,
    input  rv_core_pkg::imem_idx_t      imem_idx,
    input  rv_core_pkg::word_t          imem_data,
    input  wire logic                   start,
    input  wire logic [6:0]             prog_len,
    input  wire logic                   credit_return,
    output logic                        push,
    output rv_core_pkg::fetch_pkt_t     pkt
);

    rv_core_pkg::word_t   imem [rv_core_pkg::IMEM_WORDS];
    rv_core_pkg::addr_t   pc;
    rv_core_pkg::credit_t credits;
    logic                 running;
    // instructions still to issue
    logic [6:0]           left;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_idx] <= imem_data;
        end
    end

    // one push per cycle while running and holding a credit
    assign push      = running && (credits != '0);
    assign pkt.pc    = pc;
    assign pkt.instr = imem[rv_core_pkg::imem_idx_t'(pc[31:2])];

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pc      <= '0;
            left    <= '0;
        end else if (start) begin
            running <= (prog_len != '0);
            pc      <= '0;
            left    <= prog_len;
        end else if (push) begin
            pc   <= pc + 32'd4;
            left <= left - 7'd1;
            // last instruction of the program
            if (left == 7'd1) begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            credits <= rv_core_pkg::QUEUE_DEPTH;
        end else if (push && !credit_return) begin
            credits <= credits - 3'd1;
        end else if (!push && credit_return) begin
            credits <= credits + 3'd1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/insn_queue.sv
// no full flag; the fetch credit count keeps pushes within QUEUE_DEPTH (a power of two)
`timescale 1ns/1ps
`default_nettype none

module insn_queue (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   push,
    input  rv_core_pkg::fetch_pkt_t     push_pkt,
    input  wire logic                   pop,
    output logic                        head_valid,
    output rv_core_pkg::fetch_pkt_t     head_pkt,
    output logic                        credit_return
);

    rv_core_pkg::fetch_pkt_t entries [rv_core_pkg::QUEUE_DEPTH];

    // pointers wrap naturally at the depth
    logic [$clog2(rv_core_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(rv_core_pkg::QUEUE_DEPTH)-1:0] rd_ptr;
    rv_core_pkg::credit_t                        count;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 3'd1;
            end else if (pop && !push) begin
                count <= count - 3'd1;
            end
        end
    end

    assign head_valid = (count != '0);
    assign head_pkt   = entries[rd_ptr];

    // every freed slot goes straight back to fetch
    assign credit_return = pop;

endmodule

`default_nettype wire

//--- hdl/int_alu.sv
// sub_arith only matters for add and right shift; shifts use the low 5 bits of operand b
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  rv_core_pkg::decoded_t dec,
    input  rv_core_pkg::word_t    rs1_val,
    input  rv_core_pkg::word_t    rs2_val,
    input  rv_core_pkg::addr_t    pc,
    output rv_core_pkg::word_t    result
);

    rv_core_pkg::word_t op_a;
    rv_core_pkg::word_t op_b;
    logic [4:0]         shamt;

    always_comb begin
        case (dec.alu_a_sel)
            rv_core_pkg::A_PC:   op_a = pc;
            rv_core_pkg::A_ZERO: op_a = '0;
            default:             op_a = rs1_val;
        endcase
    end

    assign op_b  = (dec.alu_b_sel == rv_core_pkg::B_IMM) ? dec.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            rv_core_pkg::ALU_ADD:  result = dec.sub_arith ? op_a - op_b : op_a + op_b;
            rv_core_pkg::ALU_SLL:  result = op_a << shamt;
            rv_core_pkg::ALU_SLT:  result = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_core_pkg::ALU_SLTU: result = {31'd0, op_a < op_b};
            rv_core_pkg::ALU_XOR:  result = op_a ^ op_b;
            // sra when sub_arith is set
            rv_core_pkg::ALU_SR: begin
                if (dec.sub_arith) begin
                    result = rv_core_pkg::word_t'($signed(op_a) >>> shamt);
                end else begin
                    result = op_a >> shamt;
                end
            end
            rv_core_pkg::ALU_OR:   result = op_a | op_b;
            default:               result = op_a & op_b;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rv_core_pkg.sv
// shared RV32I types and sizes; queue depth and imem size are fixed here, not per instance
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  imem_idx_t;
    typedef logic [2:0]  credit_t;

    // queue capacity, also the credit count fetch starts with
    localparam credit_t QUEUE_DEPTH = 3'd4;
    localparam int      IMEM_WORDS  = 64;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // encoding follows funct3
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SR   = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        A_RS1  = 2'd0,
        A_ZERO = 2'd1,
        A_PC   = 2'd2
    } alu_a_sel_t;

    typedef enum logic {
        B_RS2 = 1'b0,
        B_IMM = 1'b1
    } alu_b_sel_t;

    typedef struct packed {
        addr_t pc;
        word_t instr;
    } fetch_pkt_t;

    typedef struct packed {
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      imm;
        alu_a_sel_t alu_a_sel;
        alu_b_sel_t alu_b_sel;
        alu_op_t    alu_op;
        logic       sub_arith;
        logic       wb_en;
    } decoded_t;

    typedef struct packed {
        addr_t    pc;
        reg_idx_t rd;
        word_t    value;
        logic     wr_en;
    } retire_t;

endpackage

`default_nettype wire

//--- hdl/rv_core_top.sv
// load imem only while idle; hold stalls execute and lets the queue fill
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   imem_we,
    input  rv_core_pkg::imem_idx_t      imem_idx,
    input  rv_core_pkg::word_t          imem_data,
    input  wire logic                   start,
    input  wire logic [6:0]             prog_len,
    input  wire logic                   hold,
    output logic                        retire_valid,
    output rv_core_pkg::retire_t        retire
);

    logic                    push;
    rv_core_pkg::fetch_pkt_t push_pkt;
    logic                    credit_return;
    logic                    head_valid;
    rv_core_pkg::fetch_pkt_t head_pkt;
    logic                    pop;

    insn_fetch i_fetch (
        .clk           (clk),
        .reset         (reset),
        .imem_we       (imem_we),
        .imem_idx      (imem_idx),
        .imem_data     (imem_data),
        .start         (start),
        .prog_len      (prog_len),
        .credit_return (credit_return),
        .push          (push),
        .pkt           (push_pkt)
    );

    insn_queue i_queue (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .push_pkt      (push_pkt),
        .pop           (pop),
        .head_valid    (head_valid),
        .head_pkt      (head_pkt),
        .credit_return (credit_return)
    );

    exec_unit i_exec (
        .clk           (clk),
        .reset         (reset),
        .head_valid    (head_valid),
        .head_pkt      (head_pkt),
        .hold          (hold),
        .pop           (pop),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator, pass/fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -j 0 --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -qx "SIMULATION PASSED" sim.log && exit 0 || exit 1

//--- rv_core.f
hdl/rv_core_pkg.sv
hdl/insn_fetch.sv
hdl/insn_queue.sv
hdl/insn_decoder.sv
hdl/int_alu.sv
hdl/exec_unit.sv
hdl/rv_core_top.sv
dv/rv_core_tb.sv
